// File: bench/mem_stage_asserts.sv
//==========================================================
// Memory stage protocol assertions, bound into the top
//==========================================================
`timescale 1ns/10ps
module mem_stage_asserts (
    input logic clk,
    input logic arst_n,
    input logic wb_en,
    input logic miss_align,
    input logic dc_miss,
    input logic rw,
    input logic st_misalign
);

    a_reset_wb_en: assert property (@(posedge clk) !arst_n |=> !wb_en)
        else $error("wb_en high after reset");

    // Misalignment wins over a miss
    a_flags_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(miss_align && dc_miss))
        else $error("miss_align and dc_miss high together");

    a_no_misal_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(rw && st_misalign))
        else $error("cache write during misaligned access");

endmodule

bind mem_stage mem_stage_asserts u_asserts (
    .clk, .arst_n, .wb_en, .miss_align, .dc_miss, .rw, .st_misalign
);

// File: bench/mem_stage_tb.sv
//==========================================================
// Memory stage testbench driving random stimulus checked
// against a reference two-way cache model
//==========================================================
`timescale 1ns/10ps
module mem_stage_tb;

    localparam int n_lines  = 12;
    localparam int n_loads  = 60;
    localparam int n_stores = 40;
    localparam int n_misal  = 20;
    localparam int n_miss   = 10;
    localparam int n_mixed  = 80;
    localparam int n_ops    = 1 + n_loads + 2 * n_stores + 2 * n_misal + n_miss + 3 + n_mixed;
    localparam int n_fills  = n_lines + 3;
    localparam int limit    = n_ops + n_fills + 50;

    logic         clk;
    logic         arst_n;
    logic         ex_en;
    mem_pkg::mem_op_e ex_mem_op;
    logic [31:0]  ex_mem_wr_data;
    logic [31:0]  ex_out;
    logic         fill_en;
    logic [31:0]  fill_addr;
    logic [127:0] fill_line;
    logic         wb_en;
    logic [31:0]  wb_out;
    logic         miss_align;
    logic         dc_miss;

    // Reference cache and pipeline state
    logic [23:0]  m_tag   [2][16];
    logic [127:0] m_line  [2][16];
    logic         m_valid [2][16];
    logic         m_lru   [16];
    logic         s_en;
    logic [3:0]   s_op;
    logic [31:0]  s_addr;
    logic [31:0]  s_wdata;
    logic         exp_en;
    logic [31:0]  exp_out;
    logic         exp_mal;
    logic         exp_miss;
    logic [31:0]  seed;
    int           cycles;
    logic [31:0]  lines[$];

    mem_stage #(.sets(16)) dut (
        .clk, .arst_n, .ex_en, .ex_mem_op, .ex_mem_wr_data, .ex_out,
        .fill_en, .fill_addr, .fill_line, .wb_en, .wb_out, .miss_align, .dc_miss
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};                 // Swap halves since low bits are weak
    endfunction

    function automatic logic is_load(input logic [3:0] op);
        return op >= 4'd1 && op <= 4'd5;
    endfunction

    function automatic logic is_store(input logic [3:0] op);
        return op >= 4'd6 && op <= 4'd8;
    endfunction

    function automatic logic misaligned(input logic [3:0] op, input logic [1:0] off);
        if (op == 4'd1 || op == 4'd6) begin
            return off != 2'd0;
        end else if (op == 4'd2 || op == 4'd3 || op == 4'd7) begin
            return off[0];
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] load_value(input logic [3:0] op, input logic [31:0] w,
                                               input logic [1:0] off);
        logic [15:0] half;
        logic [7:0]  byt;
        logic [31:0] shifted;
        half    = off[1] ? w[31:16] : w[15:0];
        shifted = w >> {off, 3'b000};
        byt     = shifted[7:0];
        case (op)
            4'd2:    return {{16{half[15]}}, half};
            4'd3:    return {16'h0000, half};
            4'd4:    return {{24{byt[7]}}, byt};
            4'd5:    return {24'h000000, byt};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] merge_value(input logic [3:0] op, input logic [31:0] old,
                                                input logic [31:0] d, input logic [1:0] off);
        logic [31:0] mask;
        mask = 32'h0000_00ff << {off, 3'b000};
        case (op)
            4'd7:    return off[1] ? {d[15:0], old[15:0]} : {old[31:16], d[15:0]};
            4'd8:    return (old & ~mask) | ((d & 32'h0000_00ff) << {off, 3'b000});
            default: return d;
        endcase
    endfunction

    // Reference model updated on each rising edge
    always @(posedge clk or negedge arst_n) begin : model
        logic        h;
        logic        hw;
        logic        mis;
        logic        f_way;
        logic [3:0]  idx;
        logic [3:0]  fidx;
        logic [31:0] old;
        logic [127:0] ln;
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                m_valid[0][i] = 1'b0;
                m_valid[1][i] = 1'b0;
                m_lru[i]      = 1'b0;
            end
            s_en     = 1'b0;
            s_op     = 4'd0;
            s_addr   = '0;
            s_wdata  = '0;
            exp_en   = 1'b0;
            exp_out  = '0;
            exp_mal  = 1'b0;
            exp_miss = 1'b0;
        end else begin
            idx = s_addr[7:4];
            h   = 1'b0;
            hw  = 1'b0;
            for (int w = 0; w < 2; w++) begin
                if (m_valid[w][idx] && m_tag[w][idx] == s_addr[31:8]) begin
                    h  = 1'b1;
                    hw = w[0];
                end
            end
            ln       = m_line[hw][idx] >> {s_addr[3:2], 5'b00000};
            old      = ln[31:0];
            mis      = misaligned(s_op, s_addr[1:0]);
            exp_en   = s_en;
            exp_mal  = s_en && mis;
            exp_miss = s_en && !mis && (is_load(s_op) || is_store(s_op)) && !h;
            exp_out  = 32'h0;
            if (s_en && !is_load(s_op) && !is_store(s_op)) begin
                exp_out = s_addr;
            end else if (s_en && !mis && h && is_load(s_op)) begin
                exp_out = load_value(s_op, old, s_addr[1:0]);
            end else if (s_en && !mis && h && is_store(s_op)) begin
                m_line[hw][idx][s_addr[3:2]*32 +: 32] = merge_value(s_op, old, s_wdata,
                                                                    s_addr[1:0]);
            end
            // Fill way chosen from the state before this edge
            fidx = fill_addr[7:4];
            if (m_valid[0][fidx] && m_tag[0][fidx] == fill_addr[31:8]) begin
                f_way = 1'b0;
            end else if (m_valid[1][fidx] && m_tag[1][fidx] == fill_addr[31:8]) begin
                f_way = 1'b1;
            end else if (!m_valid[0][fidx]) begin
                f_way = 1'b0;
            end else if (!m_valid[1][fidx]) begin
                f_way = 1'b1;
            end else begin
                f_way = m_lru[fidx];
            end
            if (h) begin
                m_lru[idx] = ~hw;                       // Any lookup hit moves LRU
            end
            if (fill_en) begin
                m_tag[f_way][fidx]   = fill_addr[31:8];
                m_line[f_way][fidx]  = fill_line;
                m_valid[f_way][fidx] = 1'b1;
                m_lru[fidx]          = ~f_way;
            end
            s_en = ex_en;
            if (ex_en) begin
                s_op    = ex_mem_op;
                s_addr  = ex_out;
                s_wdata = ex_mem_wr_data;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run went past %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Compare outputs and drive new inputs on the falling edge
    task automatic step(input logic en, input logic [3:0] op, input logic [31:0] wdata,
                        input logic [31:0] eo, input logic fen, input logic [31:0] fa);
        @(negedge clk);
        check_value("wb_en", {31'h0, wb_en}, {31'h0, exp_en});
        check_value("miss_align", {31'h0, miss_align}, {31'h0, exp_mal});
        check_value("dc_miss", {31'h0, dc_miss}, {31'h0, exp_miss});
        if (exp_en) begin
            check_value("wb_out", wb_out, exp_out);
        end
        ex_en          = en;
        ex_mem_op      = mem_pkg::mem_op_e'(op);
        ex_mem_wr_data = wdata;
        ex_out         = eo;
        fill_en        = fen;
        fill_addr      = fa;
        fill_line      = {next_rand(), next_rand(), next_rand(), next_rand()};
    endtask

    task automatic do_op(input logic [3:0] op, input logic [31:0] a);
        step(1'b1, op, next_rand(), a, 1'b0, 32'h0);
    endtask

    task automatic idle();
        step(1'b0, 4'd0, 32'h0, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic fill(input logic [31:0] a);
        step(1'b0, 4'd0, 32'h0, 32'h0, 1'b1, a);
        lines.push_back({a[31:4], 4'h0});
    endtask

    function automatic logic [31:0] cached_addr();
        logic [31:0] base;
        logic [31:0] r;
        r    = next_rand();
        base = lines[r % lines.size()];
        return {base[31:4], r[9:8], 2'b00};
    endfunction

    function automatic logic [1:0] aligned_off(input logic [3:0] op);
        logic [31:0] r;
        r = next_rand();
        if (op == 4'd1 || op == 4'd6) begin
            return 2'b00;
        end else if (op == 4'd2 || op == 4'd3 || op == 4'd7) begin
            return {r[4], 1'b0};
        end
        return r[5:4];
    endfunction

    initial begin : stimulus
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] r;
        seed           = 32'd78;
        cycles         = 0;
        arst_n         = 1'b0;
        ex_en          = 1'b0;
        ex_mem_op      = mem_pkg::op_none;
        ex_mem_wr_data = '0;
        ex_out         = '0;
        fill_en        = 1'b0;
        fill_addr      = '0;
        fill_line      = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        do_op(4'd0, 32'h0);                             // Park stage address on a tag never filled
        idle();
        idle();
        for (int i = 0; i < n_lines; i++) begin
            r = next_rand();
            fill({1'b1, r[30:8], r[3:0], 4'h0});        // Bit 31 set on every cached tag
        end
        for (int i = 0; i < n_loads; i++) begin
            op = 4'd1 + 4'(next_rand() % 5);
            a  = cached_addr();
            do_op(op, {a[31:2], aligned_off(op)});
        end
        for (int i = 0; i < n_stores; i++) begin
            op = 4'd6 + 4'(next_rand() % 3);
            a  = cached_addr();
            do_op(op, {a[31:2], aligned_off(op)});
            do_op(4'd1, a);
        end
        for (int i = 0; i < n_misal; i++) begin
            r  = next_rand();
            op = r[0] ? (r[1] ? 4'd6 : 4'd1) : (r[1] ? 4'd7 : 4'd2);
            a  = cached_addr();
            do_op(op, {a[31:2], r[2], 1'b1});           // Odd offset
            do_op(4'd1, a);
        end
        for (int i = 0; i < n_miss; i++) begin
            r = next_rand();
            do_op(4'd1 + 4'(next_rand() % 8), {2'b01, r[29:2], 2'b00});
        end
        idle();
        idle();
        fill(32'hA000_1050);                            // Three tags into set 5
        fill(32'hB000_2050);
        fill(32'hC000_3050);
        idle();
        do_op(4'd1, 32'hA000_1050);
        do_op(4'd1, 32'hB000_2054);
        do_op(4'd1, 32'hC000_3058);
        for (int i = 0; i < n_mixed; i++) begin
            r  = next_rand();
            op = 4'(r % 9);
            if (op == 4'd0) begin
                a = next_rand();
            end else if (r[5:4] == 2'b00) begin
                a = {2'b01, r[29:0]};
            end else begin
                a = cached_addr();
                a = {a[31:2], r[9:8]};
            end
            do_op(op, a);
        end
        idle();
        idle();
        idle();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: build.f
common/mem_pkg.sv
hw/mem_op_decode.sv
dcache/dcache_ways.sv
hw/mem_ctrl.sv
hw/mem_result.sv
hw/mem_stage.sv
bench/mem_stage_asserts.sv
bench/mem_stage_tb.sv

// File: common/mem_pkg.sv
//==========================================================
// Memory stage shared widths, operation codes and the
// address field positions used by the data cache
//==========================================================
package mem_pkg;

    localparam int word_w     = 32;     // Data word
    localparam int line_w     = 128;    // Cache line, four words
    localparam int byte_off_w = 2;      // Address bits 1:0
    localparam int word_sel_w = 2;      // Address bits 3:2
    localparam int index_lsb  = 4;      // Lowest set index bit

    // Memory operation carried down from EX
    typedef enum logic [3:0] {
        op_none = 4'd0,     // Pass EX result through
        op_lw   = 4'd1,
        op_lh   = 4'd2,
        op_lhu  = 4'd3,
        op_lb   = 4'd4,
        op_lbu  = 4'd5,
        op_sw   = 4'd6,
        op_sh   = 4'd7,
        op_sb   = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

endpackage

// File: dcache/dcache_ways.sv
//==========================================================
// Two-way set-associative data cache with per-set LRU,
// line fill port and single word write port
//==========================================================
`timescale 1ns/10ps
module dcache_ways #(
    parameter int sets = 16
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [mem_pkg::word_w-1:0] addr,
    input  logic                       rw,
    input  logic [mem_pkg::word_w-1:0] wr_data,
    input  logic                       fill_en,
    input  logic [mem_pkg::word_w-1:0] fill_addr,
    input  logic [mem_pkg::line_w-1:0] fill_line,
    output logic                       hit,
    output logic                       hitway,
    output logic [mem_pkg::word_w-1:0] data0_rd,
    output logic [mem_pkg::word_w-1:0] data1_rd
);

    localparam int index_w = $clog2(sets);
    localparam int tag_w   = mem_pkg::word_w - mem_pkg::index_lsb - index_w;
    localparam int sel_lsb = mem_pkg::index_lsb - mem_pkg::word_sel_w;

    logic [tag_w-1:0]               tag_mem  [2][sets];
    logic [mem_pkg::line_w-1:0]     line_mem [2][sets];
    logic [1:0][sets-1:0]           valid;
    logic [sets-1:0]                lru;        // Way to replace next

    logic [index_w-1:0]             idx;
    logic [tag_w-1:0]               tag;
    logic [mem_pkg::word_sel_w-1:0] wsel;       // Word within the line
    logic [1:0]                     way_hit;
    logic [index_w-1:0]             f_idx;
    logic [tag_w-1:0]               f_tag;
    logic [1:0]                     f_match;    // Fill tag already cached
    logic                           f_way;

    assign idx   = addr[mem_pkg::index_lsb +: index_w];
    assign tag   = addr[mem_pkg::word_w-1 -: tag_w];
    assign wsel  = addr[sel_lsb +: mem_pkg::word_sel_w];
    assign f_idx = fill_addr[mem_pkg::index_lsb +: index_w];
    assign f_tag = fill_addr[mem_pkg::word_w-1 -: tag_w];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid[w][idx] && (tag_mem[w][idx] == tag);
            f_match[w] = valid[w][f_idx] && (tag_mem[w][f_idx] == f_tag);
        end
    end

    assign hit      = |way_hit;
    assign hitway   = way_hit[1];
    assign data0_rd = line_mem[0][idx][wsel*mem_pkg::word_w +: mem_pkg::word_w];
    assign data1_rd = line_mem[1][idx][wsel*mem_pkg::word_w +: mem_pkg::word_w];

    // Replacement choice for the fill
    always_comb begin
        if (f_match[0]) begin
            f_way = 1'b0;
        end else if (f_match[1]) begin
            f_way = 1'b1;
        end else if (!valid[0][f_idx]) begin
            f_way = 1'b0;                           // Free way, way 0 first
        end else if (!valid[1][f_idx]) begin
            f_way = 1'b1;
        end else begin
            f_way = lru[f_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rw && hit) begin
            line_mem[hitway][idx][wsel*mem_pkg::word_w +: mem_pkg::word_w] <= wr_data;
        end
        if (fill_en) begin
            tag_mem[f_way][f_idx]  <= f_tag;
            line_mem[f_way][f_idx] <= fill_line;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            lru   <= '0;
        end else begin
            if (hit) begin
                lru[idx] <= ~hitway;                // Point at the other way
            end
            if (fill_en) begin
                valid[f_way][f_idx] <= 1'b1;
                lru[f_idx]          <= ~f_way;
            end
        end
    end

endmodule

// File: hw/mem_ctrl.sv
//==========================================================
// Memory access control, load extraction and store merge
//==========================================================
`timescale 1ns/10ps
module mem_ctrl (
    input  logic                       st_en,
    input  mem_pkg::mem_op_e           st_op,
    input  mem_pkg::access_size_e      st_size,
    input  logic                       st_signed,
    input  logic                       st_store,
    input  logic                       st_misalign,
    input  logic [mem_pkg::word_w-1:0] st_addr,
    input  logic [mem_pkg::word_w-1:0] st_wr_data,
    input  logic                       hit,
    input  logic                       hitway,
    input  logic [mem_pkg::word_w-1:0] data0_rd,
    input  logic [mem_pkg::word_w-1:0] data1_rd,
    output logic [mem_pkg::word_w-1:0] addr,
    output logic                       rw,          // 1 writes the hit word
    output logic [mem_pkg::word_w-1:0] wr_data,
    output logic [mem_pkg::word_w-1:0] out,
    output logic                       miss
);

    logic [mem_pkg::byte_off_w-1:0] offset;
    logic [mem_pkg::word_w-1:0]     rd_word;        // Word of the hit way
    logic                           is_mem;
    logic [7:0]                     ld_byte;
    logic [15:0]                    ld_half;

    assign addr    = st_addr;
    assign offset  = st_addr[mem_pkg::byte_off_w-1:0];
    assign rd_word = hitway ? data1_rd : data0_rd;
    assign is_mem  = st_op inside {mem_pkg::op_lw, mem_pkg::op_lh, mem_pkg::op_lhu,
                                   mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sw,
                                   mem_pkg::op_sh, mem_pkg::op_sb};
    assign ld_byte = rd_word[offset*8 +: 8];
    assign ld_half = rd_word[offset[1]*16 +: 16];   // Upper half when offset is 2

    always_comb begin
        rw      = 1'b0;
        wr_data = rd_word;
        out     = '0;
        miss    = 1'b0;
        if (st_en && !is_mem) begin
            out = st_addr;                          // EX result straight through
        end else if (st_en && !st_misalign) begin
            if (!hit) begin
                miss = 1'b1;
            end else if (st_store) begin
                rw = 1'b1;
                // Merge new bytes into the cached word
                case (st_size)
                    mem_pkg::size_byte: wr_data[offset*8 +: 8] = st_wr_data[7:0];
                    mem_pkg::size_half: wr_data[offset[1]*16 +: 16] = st_wr_data[15:0];
                    default:            wr_data = st_wr_data;
                endcase
            end else begin
                case (st_size)
                    mem_pkg::size_byte: out = {{24{st_signed & ld_byte[7]}}, ld_byte};
                    mem_pkg::size_half: out = {{16{st_signed & ld_half[15]}}, ld_half};
                    default:            out = rd_word;
                endcase
            end
        end
    end

endmodule

// File: hw/mem_op_decode.sv
//==========================================================
// EX/MEM stage register with memory operation decode
//==========================================================
`timescale 1ns/10ps
module mem_op_decode (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       ex_en,
    input  mem_pkg::mem_op_e           ex_mem_op,
    input  logic [mem_pkg::word_w-1:0] ex_mem_wr_data,
    input  logic [mem_pkg::word_w-1:0] ex_out,
    output logic                       st_en,
    output mem_pkg::mem_op_e           st_op,
    output mem_pkg::access_size_e      st_size,
    output logic                       st_signed,
    output logic                       st_store,
    output logic                       st_misalign,
    output logic [mem_pkg::word_w-1:0] st_addr,
    output logic [mem_pkg::word_w-1:0] st_wr_data
);

    logic [mem_pkg::byte_off_w-1:0] offset;      // Byte offset of EX result
    logic                           is_mem;      // Load or store
    mem_pkg::access_size_e          size_d;
    logic                           signed_d;
    logic                           store_d;
    logic                           misalign_d;

    assign offset = ex_out[mem_pkg::byte_off_w-1:0];

    always_comb begin
        is_mem   = ex_mem_op inside {mem_pkg::op_lw, mem_pkg::op_lh, mem_pkg::op_lhu,
                                     mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sw,
                                     mem_pkg::op_sh, mem_pkg::op_sb};
        signed_d = (ex_mem_op == mem_pkg::op_lh) || (ex_mem_op == mem_pkg::op_lb);
        store_d  = ex_mem_op inside {mem_pkg::op_sw, mem_pkg::op_sh, mem_pkg::op_sb};
        case (ex_mem_op)
            mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: size_d = mem_pkg::size_half;
            mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb: size_d = mem_pkg::size_byte;
            default:                                         size_d = mem_pkg::size_word;
        endcase
        // Alignment checked once here, before the register
        case (size_d)
            mem_pkg::size_word: misalign_d = is_mem && (offset != '0);
            mem_pkg::size_half: misalign_d = is_mem && offset[0];
            default:            misalign_d = 1'b0;  // Bytes always aligned
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_en <= 1'b0;
        end else begin
            st_en <= ex_en;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_en) begin                            // Hold payload while idle
            st_op       <= ex_mem_op;
            st_size     <= size_d;
            st_signed   <= signed_d;
            st_store    <= store_d;
            st_misalign <= misalign_d;
            st_addr     <= ex_out;
            st_wr_data  <= ex_mem_wr_data;
        end
    end

endmodule

// File: hw/mem_result.sv
//==========================================================
// MEM/WB register for the result and fault flags
//==========================================================
`timescale 1ns/10ps
module mem_result (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       st_en,
    input  logic                       st_misalign,
    input  logic [mem_pkg::word_w-1:0] out,
    input  logic                       miss,
    output logic                       wb_en,
    output logic [mem_pkg::word_w-1:0] wb_out,
    output logic                       miss_align,
    output logic                       dc_miss
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en      <= 1'b0;
            miss_align <= 1'b0;
            dc_miss    <= 1'b0;
        end else begin
            wb_en      <= st_en;
            miss_align <= st_en && st_misalign;
            dc_miss    <= st_en && miss;            // Never set with misalign
        end
    end

    // Misaligned access returns zero
    always_ff @(posedge clk) begin
        wb_out <= (st_en && st_misalign) ? '0 : out;
    end

endmodule

// File: hw/mem_stage.sv
//==========================================================
// Memory access stage, decode, data cache, control and WB
//==========================================================
`timescale 1ns/10ps
module mem_stage #(
    parameter int sets = 16
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       ex_en,
    input  mem_pkg::mem_op_e           ex_mem_op,
    input  logic [mem_pkg::word_w-1:0] ex_mem_wr_data,
    input  logic [mem_pkg::word_w-1:0] ex_out,
    input  logic                       fill_en,
    input  logic [mem_pkg::word_w-1:0] fill_addr,
    input  logic [mem_pkg::line_w-1:0] fill_line,
    output logic                       wb_en,
    output logic [mem_pkg::word_w-1:0] wb_out,
    output logic                       miss_align,
    output logic                       dc_miss
);

    logic                       st_en;
    mem_pkg::mem_op_e           st_op;
    mem_pkg::access_size_e      st_size;
    logic                       st_signed;
    logic                       st_store;
    logic                       st_misalign;
    logic [mem_pkg::word_w-1:0] st_addr;
    logic [mem_pkg::word_w-1:0] st_wr_data;
    logic                       hit;
    logic                       hitway;
    logic [mem_pkg::word_w-1:0] data0_rd;
    logic [mem_pkg::word_w-1:0] data1_rd;
    logic [mem_pkg::word_w-1:0] addr;
    logic                       rw;
    logic [mem_pkg::word_w-1:0] wr_data;
    logic [mem_pkg::word_w-1:0] out;
    logic                       miss;

    mem_op_decode u_decode (
        .clk, .arst_n, .ex_en, .ex_mem_op, .ex_mem_wr_data, .ex_out,
        .st_en, .st_op, .st_size, .st_signed, .st_store, .st_misalign,
        .st_addr, .st_wr_data
    );

    dcache_ways #(.sets(sets)) u_dcache (
        .clk, .arst_n, .addr, .rw, .wr_data, .fill_en, .fill_addr, .fill_line,
        .hit, .hitway, .data0_rd, .data1_rd
    );

    mem_ctrl u_ctrl (
        .st_en, .st_op, .st_size, .st_signed, .st_store, .st_misalign,
        .st_addr, .st_wr_data, .hit, .hitway, .data0_rd, .data1_rd,
        .addr, .rw, .wr_data, .out, .miss
    );

    mem_result u_result (
        .clk, .arst_n, .st_en, .st_misalign, .out, .miss,
        .wb_en, .wb_out, .miss_align, .dc_miss
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module mem_stage_tb -f build.f
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/Vmem_stage_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
